// File: flist.f
common/ising_pkg.sv
ising_core/weight_store.sv
ising_core/spin_sweeper.sv
ising_core/ising_core.sv
design/ising_axi.sv
tests/ising_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the Ising machine testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module ising_tb \
        --Mdir obj_dir -f flist.f; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vising_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0

// File: tests/ising_tb.sv
/*
 * Directed testbench for the Ising machine top level.
 * Drives the memory-mapped port and checks results against a software sweep model.
 */

`timescale 1ns/1ps

module ising_tb;

    localparam int N = 4;
    localparam logic [31:0] PHASE_ADDR = {ising_pkg::PHASE_ADDR_MASK, 12'h000};

    logic        clk = 1'b0;
    logic        axi_rstn, arvalid_q, rready, wready;
    logic [31:0] araddr_q, wr_addr, wdata, rdata;
    logic        rvalid, rresp;
    integer      seed = 32'h0cec3357;
    int          wt [N][N];              // Couplings as the model sees them.
    string       test_name;

    ising_axi #(.N(N)) uut (
        .clk       (clk),
        .axi_rstn  (axi_rstn),
        .arvalid_q (arvalid_q),
        .araddr_q  (araddr_q),
        .rready    (rready),
        .rvalid    (rvalid),
        .rresp     (rresp),
        .rdata     (rdata),
        .wready    (wready),
        .wr_addr   (wr_addr),
        .wdata     (wdata)
    );

    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else
            abort_run($sformatf("[FAIL] %s %s: expected %h actual %h",
                                test_name, what, exp, act));
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        wready  <= 1'b1;
        wr_addr <= addr;
        wdata   <= data;
        @(posedge clk);
        wready  <= 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        int          wait_cnt;
        int unsigned stall;
        wait_cnt = 0;
        stall    = $unsigned($random(seed)) % 4;
        @(posedge clk);
        arvalid_q <= 1'b1;
        araddr_q  <= addr;
        @(posedge clk);
        arvalid_q <= 1'b0;
        @(negedge clk);
        while (!rvalid && wait_cnt < 20) begin
            wait_cnt++;
            @(negedge clk);
        end
        if (!rvalid) begin
            abort_run($sformatf("Timeout waiting for rvalid on a read of %h.", addr));
        end else begin
            data = rdata;
            check_eq("rresp", 32'd0, {31'd0, rresp});
            repeat (stall) begin                     // Back-pressure.
                @(negedge clk);
                check_eq("rvalid held", 32'd1, {31'd0, rvalid});
                check_eq("rdata held", data, rdata);
            end
            @(posedge clk);
            rready <= 1'b1;
            @(posedge clk);
            rready <= 1'b0;
            @(negedge clk);
            check_eq("rvalid cleared", 32'd0, {31'd0, rvalid});
            check_eq("rdata cleared", 32'd0, rdata);
        end
    endtask

    task automatic wait_done(output logic [31:0] phase);
        int polls;
        polls = 0;
        read_reg(PHASE_ADDR, phase);
        while (!phase[31] && polls < 400) begin
            polls++;
            read_reg(PHASE_ADDR, phase);
        end
        if (!phase[31])
            abort_run("Timeout waiting for the done flag in the phase word.");
    endtask

    function automatic logic [31:0] weight_addr(input int i, input int j);
        return {ising_pkg::WEIGHT_ADDR_MASK, 24'h0} | (32'(i) << 8) | (32'(j) << 2);
    endfunction

    function automatic logic [31:0] expect_phase(input logic [N-1:0] spins);
        return {1'b1, {(31 - N){1'b0}}, spins};
    endfunction

    task automatic write_weights();
        for (int i = 0; i < N; i++)
            for (int j = 0; j < N; j++)
                write_reg(weight_addr(i, j), 32'(wt[i][j]));
    endtask

    // Software sweep, same order and noise schedule as the hardware.
    task automatic model_run(input int cutoff, input int sweeps, output logic [N-1:0] spins);
        logic [15:0] lfsr;
        int          field;
        logic        spin_new;
        spins = '1;
        lfsr  = ising_pkg::LFSR_SEED;
        for (int s = 0; s < sweeps; s++) begin
            for (int i = 0; i < N; i++) begin
                field = 0;
                for (int j = 0; j < N; j++)
                    if (j != i)
                        field += spins[j] ? wt[i][j] : -wt[i][j];
                lfsr     = lfsr[0] ? ((lfsr >> 1) ^ ising_pkg::LFSR_TAPS) : (lfsr >> 1);
                spin_new = (field > 0) ? 1'b1 : (field < 0) ? 1'b0 : spins[i];
                if (s < cutoff && lfsr[1:0] == 2'b00)
                    spin_new = ~spin_new;
                spins[i] = spin_new;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_default_read();
        logic [31:0] data;
        test_name = "test_default_read";
        read_reg(32'h1234_5678, data);
        check_eq("unmapped read", ising_pkg::DEFAULT_RDATA, data);
        read_reg(PHASE_ADDR, data);
        check_eq("phase after reset", expect_phase('1), data);
    endtask

    task automatic test_weight_rw();
        logic [31:0] data;
        logic [31:0] vals [N][N];
        test_name = "test_weight_rw";
        for (int i = 0; i < N; i++)
            for (int j = 0; j < N; j++) begin
                vals[i][j] = $random(seed);
                write_reg(weight_addr(i, j), vals[i][j]);
            end
        write_reg(weight_addr(5, 1), ~vals[1][1]);   // Would alias onto (1,1) if kept.
        for (int i = 0; i < N; i++)
            for (int j = 0; j < N; j++) begin
                read_reg(weight_addr(i, j), data);
                check_eq($sformatf("weight %0d,%0d", i, j),
                         {{24{vals[i][j][7]}}, vals[i][j][7:0]}, data);
            end
        read_reg(weight_addr(5, 1), data);
        check_eq("out of range row", 32'd0, data);
    endtask

    task automatic test_ferro_run();
        logic [31:0] phase;
        test_name = "test_ferro_run";
        for (int i = 0; i < N; i++)
            for (int j = 0; j < N; j++)
                wt[i][j] = (i == j) ? -100 : 3;      // Strong self coupling, never summed.
        write_weights();
        write_reg(ising_pkg::CTR_CUTOFF_ADDR, 32'd0);
        write_reg(ising_pkg::CTR_MAX_ADDR, 32'd2);
        write_reg(ising_pkg::START_ADDR, 32'd5);
        wait_done(phase);
        check_eq("ferro spins", expect_phase('1), phase);
    endtask

    task automatic test_model_run();
        logic [31:0]  phase;
        logic [N-1:0] spins;
        test_name = "test_model_run";
        for (int i = 0; i < N; i++)
            for (int j = i; j < N; j++) begin
                wt[i][j] = (i == j) ? 0 : $random(seed) % 16;  // Symmetric couplings.
                wt[j][i] = wt[i][j];
            end
        write_weights();
        write_reg(ising_pkg::CTR_CUTOFF_ADDR, 32'd3);
        write_reg(ising_pkg::CTR_MAX_ADDR, 32'd6);
        write_reg(ising_pkg::START_ADDR, 32'd5);
        wait_done(phase);
        model_run(3, 6, spins);
        check_eq("model spins", expect_phase(spins), phase);
    endtask

    task automatic test_restart();
        logic [31:0]  phase;
        logic [N-1:0] spins;
        test_name = "test_restart";
        write_reg(ising_pkg::CTR_MAX_ADDR, 32'd1000);
        write_reg(ising_pkg::START_ADDR, 32'd5);
        read_reg(PHASE_ADDR, phase);
        read_reg(PHASE_ADDR, phase);
        check_eq("done mid run", 32'd0, {31'd0, phase[31]});
        write_reg(ising_pkg::START_ADDR, 32'd200);
        read_reg(PHASE_ADDR, phase);
        check_eq("held phase", {{(32 - N){1'b0}}, {N{1'b1}}}, phase);
        write_reg(ising_pkg::CTR_MAX_ADDR, 32'd4);
        wait_done(phase);
        model_run(3, 4, spins);
        check_eq("restart spins", expect_phase(spins), phase);
    endtask

    initial begin
        axi_rstn  = 1'b0;
        arvalid_q = 1'b0;
        araddr_q  = '0;
        rready    = 1'b0;
        wready    = 1'b0;
        wr_addr   = '0;
        wdata     = '0;
        repeat (16) @(posedge clk);
        axi_rstn <= 1'b1;
        test_default_read();
        test_weight_rw();
        test_ferro_run();
        test_model_run();
        test_restart();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: design/ising_axi.sv
/*
 * Ising machine top level on the memory-mapped port.
 * Control registers, hold counter and read data register.
 */

`timescale 1ns/1ps

module ising_axi #(
    parameter int N        = 4,
    parameter int WEIGHT_W = 8,
    parameter int FIELD_W  = 16
) (
    input  logic        clk,
    input  logic        axi_rstn,

    // Read port.
    input  logic        arvalid_q,
    input  logic [31:0] araddr_q,
    input  logic        rready,
    output logic        rvalid,
    output logic        rresp,
    output logic [31:0] rdata,

    // Write port.
    input  logic        wready,
    input  logic [31:0] wr_addr,
    input  logic [31:0] wdata
);

    ising_pkg::axi_wr_t    wr;
    ising_pkg::ising_cfg_t cfg;
    logic [31:0]           hold_cnt;
    logic                  ising_rstn;
    logic [31:0]           phase_word;
    logic [31:0]           weight_word;
    logic                  phase_sel;
    logic                  weight_sel;
    logic [31:0]           rd_mux;

    assign wr = '{strobe: wready, addr: wr_addr, data: wdata};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control registers and hold counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            cfg      <= '0;
            hold_cnt <= '0;
        end else begin
            if (wr.strobe && wr.addr == ising_pkg::CTR_CUTOFF_ADDR)
                cfg.counter_cutoff <= wr.data;
            if (wr.strobe && wr.addr == ising_pkg::CTR_MAX_ADDR)
                cfg.counter_max <= wr.data;

            if (wr.strobe && wr.addr == ising_pkg::START_ADDR)
                hold_cnt <= wr.data;                          // Restart the hold.
            else if (hold_cnt != '0)
                hold_cnt <= hold_cnt - 32'd1;
        end
    end

    // Core runs only once the count has drained; bus reset holds it too.
    assign ising_rstn = axi_rstn && (hold_cnt == '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign phase_sel  = (araddr_q[31:12] == ising_pkg::PHASE_ADDR_MASK);
    assign weight_sel = (araddr_q[31:24] == ising_pkg::WEIGHT_ADDR_MASK);

    assign rd_mux = phase_sel  ? phase_word  :
                    weight_sel ? weight_word :
                                 ising_pkg::DEFAULT_RDATA;

    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            rvalid <= 1'b0;
            rdata  <= '0;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
            rdata  <= '0;
        end else if (arvalid_q && !rvalid) begin          // Busy port drops requests.
            rvalid <= 1'b1;
            rdata  <= rd_mux;
        end
    end

    assign rresp = 1'b0;                                   // Always OKAY.

    ising_core #(
        .N        (N),
        .WEIGHT_W (WEIGHT_W),
        .FIELD_W  (FIELD_W)
    ) u_core (
        .clk        (clk),
        .axi_rstn   (axi_rstn),
        .ising_rstn (ising_rstn),
        .cfg        (cfg),
        .wr         (wr),
        .rd_addr    (araddr_q),
        .phase      (phase_word),
        .rdata      (weight_word)
    );

endmodule

// File: ising_core/ising_core.sv
/*
 * Ising core, weight store plus spin sweeper.
 */

`timescale 1ns/1ps

module ising_core #(
    parameter int N        = 4,
    parameter int WEIGHT_W = 8,
    parameter int FIELD_W  = 16
) (
    input  logic                  clk,
    input  logic                  axi_rstn,
    input  logic                  ising_rstn,
    input  ising_pkg::ising_cfg_t cfg,
    input  ising_pkg::axi_wr_t    wr,
    input  logic [31:0]           rd_addr,
    output logic [31:0]           phase,
    output logic [31:0]           rdata
);

    localparam int IDX_W = $clog2(N);

    logic [IDX_W-1:0]           row;
    logic [IDX_W-1:0]           col;
    logic signed [WEIGHT_W-1:0] weight;

    weight_store #(
        .N        (N),
        .WEIGHT_W (WEIGHT_W)
    ) u_weights (
        .clk        (clk),
        .axi_rstn   (axi_rstn),
        .wr         (wr),
        .host_addr  (rd_addr),
        .row        (row),
        .col        (col),
        .host_rdata (rdata),
        .weight     (weight)
    );

    spin_sweeper #(
        .N        (N),
        .WEIGHT_W (WEIGHT_W),
        .FIELD_W  (FIELD_W)
    ) u_sweeper (
        .clk        (clk),
        .ising_rstn (ising_rstn),
        .cfg        (cfg),
        .weight     (weight),
        .row        (row),
        .col        (col),
        .phase      (phase)
    );

endmodule

// File: ising_core/spin_sweeper.sv
/*
 * Sequential spin sweeper with annealing noise.
 * Accumulates each local field, decides the spin, counts sweeps.
 */

`timescale 1ns/1ps

module spin_sweeper #(
    parameter int N        = 4,
    parameter int WEIGHT_W = 8,
    parameter int FIELD_W  = 16
) (
    input  logic                       clk,
    input  logic                       ising_rstn,
    input  ising_pkg::ising_cfg_t      cfg,
    input  logic signed [WEIGHT_W-1:0] weight,
    output logic [$clog2(N)-1:0]       row,
    output logic [$clog2(N)-1:0]       col,
    output logic [31:0]                phase
);

    localparam int IDX_W = $clog2(N);

    ising_pkg::sweep_state_t   state;
    logic [N-1:0]              spins;       // 1 is +1, 0 is -1.
    logic [31:0]               sweep_cnt;
    logic [32:0]               sweep_nxt;
    logic signed [FIELD_W-1:0] field;
    logic signed [FIELD_W-1:0] w_ext;
    logic [15:0]               lfsr;
    logic [15:0]               lfsr_nxt;
    logic                      done;
    logic                      decision;
    logic                      flip;

    assign w_ext     = {{(FIELD_W-WEIGHT_W){weight[WEIGHT_W-1]}}, weight};
    assign sweep_nxt = {1'b0, sweep_cnt} + 33'd1;

    // Galois step, taps folded in when a one falls out.
    assign lfsr_nxt = lfsr[0] ? ((lfsr >> 1) ^ ising_pkg::LFSR_TAPS) : (lfsr >> 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Spin decision
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (field == '0)
            decision = spins[row];                           // Tie keeps the spin.
        else
            decision = !field[FIELD_W-1];
        flip = (sweep_cnt < cfg.counter_cutoff) && (lfsr_nxt[1:0] == 2'b00);
    end

    always_ff @(posedge clk) begin
        if (!ising_rstn) begin
            state     <= (cfg.counter_max == '0) ? ising_pkg::SW_DONE : ising_pkg::SW_ACCUM;
            spins     <= '1;
            sweep_cnt <= '0;
            row       <= '0;
            col       <= '0;
            field     <= '0;
            lfsr      <= ising_pkg::LFSR_SEED;
            done      <= 1'b0;
        end else begin
            case (state)
                ising_pkg::SW_ACCUM: begin
                    if (col != row)                          // No self coupling.
                        field <= spins[col] ? field + w_ext : field - w_ext;
                    if (col == IDX_W'(N - 1)) begin
                        col   <= '0;
                        state <= ising_pkg::SW_DECIDE;
                    end else begin
                        col <= col + 1'b1;
                    end
                end

                ising_pkg::SW_DECIDE: begin
                    lfsr       <= lfsr_nxt;
                    spins[row] <= decision ^ flip;
                    field      <= '0;
                    if (row == IDX_W'(N - 1)) begin
                        // End of a sweep.
                        row       <= '0;
                        sweep_cnt <= sweep_nxt[31:0];
                        if (sweep_nxt >= {1'b0, cfg.counter_max})
                            state <= ising_pkg::SW_DONE;
                        else
                            state <= ising_pkg::SW_ACCUM;
                    end else begin
                        row   <= row + 1'b1;
                        state <= ising_pkg::SW_ACCUM;
                    end
                end

                ising_pkg::SW_DONE: begin
                    done <= 1'b1;                             // Spins stay frozen.
                end

                default: begin
                    state <= ising_pkg::SW_ACCUM;
                end
            endcase
        end
    end

    // Done on bit 31, spins from bit 0 up.
    assign phase = {done, {(31 - N){1'b0}}, spins};

endmodule

// File: ising_core/weight_store.sv
/*
 * Coupling weight register file, N x N signed entries.
 * One host write port, a host read port and a sweeper read port.
 */

`timescale 1ns/1ps

module weight_store #(
    parameter int N        = 4,
    parameter int WEIGHT_W = 8
) (
    input  logic                       clk,
    input  logic                       axi_rstn,
    input  ising_pkg::axi_wr_t         wr,
    input  logic [31:0]                host_addr,
    input  logic [$clog2(N)-1:0]       row,
    input  logic [$clog2(N)-1:0]       col,
    output logic [31:0]                host_rdata,
    output logic signed [WEIGHT_W-1:0] weight
);

    localparam int IDX_W = $clog2(N);

    logic signed [WEIGHT_W-1:0] mem [N][N];

    logic [7:0]                 w_row;
    logic [5:0]                 w_col;
    logic                       wr_hit;
    logic [7:0]                 h_row;
    logic [5:0]                 h_col;
    logic signed [WEIGHT_W-1:0] h_w;

    // Row in addr[15:8], column in addr[7:2].
    assign w_row  = wr.addr[15:8];
    assign w_col  = wr.addr[7:2];
    assign wr_hit = wr.strobe && (wr.addr[31:24] == ising_pkg::WEIGHT_ADDR_MASK) &&
                    (w_row < N) && (w_col < N);

    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N; c++) begin
                    mem[r][c] <= '0;
                end
            end
        end else if (wr_hit) begin
            mem[w_row[IDX_W-1:0]][w_col[IDX_W-1:0]] <= wr.data[WEIGHT_W-1:0];
        end
    end

    // Host readback, zero outside the array.
    assign h_row = host_addr[15:8];
    assign h_col = host_addr[7:2];

    always_comb begin
        h_w        = mem[h_row[IDX_W-1:0]][h_col[IDX_W-1:0]];
        host_rdata = '0;
        if (h_row < N && h_col < N)
            host_rdata = {{(32-WEIGHT_W){h_w[WEIGHT_W-1]}}, h_w};
    end

    assign weight = mem[row][col];

endmodule

// File: common/ising_pkg.sv
/*
 * Ising machine shared definitions.
 * Address map, LFSR constants, bus and config structs, sweep states.
 */

package ising_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [19:0] PHASE_ADDR_MASK  = 20'h40000;      // Against addr[31:12].
    localparam logic [7:0]  WEIGHT_ADDR_MASK = 8'h50;          // Against addr[31:24].

    localparam logic [31:0] CTR_CUTOFF_ADDR  = 32'h6000_0000;
    localparam logic [31:0] CTR_MAX_ADDR     = 32'h6000_0004;
    localparam logic [31:0] START_ADDR       = 32'h6000_0008;

    localparam logic [31:0] DEFAULT_RDATA    = 32'hAAAA_AAAA;  // Unmapped reads.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Noise source
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [15:0] LFSR_SEED = 16'hACE1;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;              // Galois, right shift.

    // Host write strobe with address and data.
    typedef struct packed {
        logic        strobe;
        logic [31:0] addr;
        logic [31:0] data;
    } axi_wr_t;

    // Run configuration written by the host.
    typedef struct packed {
        logic [31:0] counter_max;
        logic [31:0] counter_cutoff;
    } ising_cfg_t;

    typedef enum logic [1:0] {
        SW_ACCUM,
        SW_DECIDE,
        SW_DONE
    } sweep_state_t;

endpackage
